// File: filelist.f
hw/burst_read_pkg.sv
hw/burst_read_master.sv
hw/read_buffer.sv
hw/word_packer.sv
hw/burst_read_engine.sv
testbench/avalon_burst_memory.sv
testbench/tb_burst_read_engine.sv

// File: testbench/tb_burst_read_engine.sv
`timescale 1ns/1ns

module tb_burst_read_engine;

    localparam int  BURST_SIZE = 8;
    localparam int  WIDTHB = 4;
    localparam int  FIFO_DEPTH = 32;
    localparam int  OUT_CREDITS = 4;
    localparam int  RESET_CYCLES = 8;
    localparam int  NUM_COMMANDS = 30;
    localparam int  IDLE_CHECK_CYCLES = 20;
    localparam int  DONE_TIMEOUT = 20000;
    localparam int  STARVE_CYCLES = 150;
    localparam time DRIVE_DELAY = 5;

    logic                      clock = 1'b0;
    logic                      clock_sreset;
    burst_read_pkg::address_t  address;
    burst_read_pkg::count_t    words;
    logic                      go;
    logic                      busy;
    burst_read_pkg::address_t  m_address;
    burst_read_pkg::word_t     m_readdata;
    logic [1:0]                m_byteenable;
    logic [WIDTHB-1:0]         m_burstcount;
    logic                      m_read;
    logic                      m_readdatavalid;
    logic                      m_waitrequest;
    logic                      out_valid;
    burst_read_pkg::beat_t     out_data;
    logic                      out_last;
    logic                      out_credit = 1'b0;
    logic                      stall = 1'b0;

    logic [31:0]               lfsr_state = 32'h4fb4;
    burst_read_pkg::beat_t     expected_beats [$];
    logic                      expected_last [$];
    logic                      cmd_open = 1'b0;     // go seen and final beat not yet seen
    burst_read_pkg::address_t  next_addr;
    int unsigned               issued;
    int unsigned               cmd_words;
    int unsigned               beats_seen = 0;
    int unsigned               credits_seen = 0;
    int unsigned               credits_sent = 0;
    int unsigned               credit_gap = 0;
    logic                      in_reset;
    int                        n;

    always #50 clock = ~clock;

    burst_read_engine #(
        .BURST_SIZE (BURST_SIZE),
        .WIDTHB (WIDTHB),
        .FIFO_DEPTH (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_burst_read_engine (
        .clock (clock),
        .clock_sreset (clock_sreset),
        .address (address),
        .words (words),
        .go (go),
        .busy (busy),
        .m_address (m_address),
        .m_readdata (m_readdata),
        .m_byteenable (m_byteenable),
        .m_burstcount (m_burstcount),
        .m_read (m_read),
        .m_readdatavalid (m_readdatavalid),
        .m_waitrequest (m_waitrequest),
        .out_valid (out_valid),
        .out_data (out_data),
        .out_last (out_last),
        .out_credit (out_credit)
    );

    avalon_burst_memory #(
        .WIDTHB (WIDTHB)
    ) i_avalon_burst_memory (
        .clock (clock),
        .clock_sreset (clock_sreset),
        .stall (stall),
        .m_address (m_address),
        .m_read (m_read),
        .m_burstcount (m_burstcount),
        .m_waitrequest (m_waitrequest),
        .m_readdata (m_readdata),
        .m_readdatavalid (m_readdatavalid)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic burst_read_pkg::word_t pattern_word(input burst_read_pkg::address_t a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERR time=%0t signal=%s expected=%h actual=%h",
                                        $time, name, expected, actual));
        end
    endtask

    // earlier word low and odd tail padded with zero
    task automatic push_expected(input burst_read_pkg::address_t base,
                                 input burst_read_pkg::count_t count);
        burst_read_pkg::word_t low;
        burst_read_pkg::word_t high;
        int                    i;
        for (i = 0; i < count; i += 2) begin
            low = pattern_word(base + 2 * i);
            high = (i + 1 < count) ? pattern_word(base + 2 * i + 2) : 16'h0000;
            expected_beats.push_back({high, low});
            expected_last.push_back(i + 2 >= count);
        end
    endtask

    task automatic run_command(input int index);
        burst_read_pkg::address_t cmd_address;
        burst_read_pkg::count_t   cmd_count;
        int                       idle;
        int                       waited;
        @(posedge clock);
        idle = take_bits(2);
        cmd_address = take_bits(16) & 32'h0000_fffe;   // even and below 64K
        cmd_count = burst_read_pkg::count_t'(take_bits(6) % 40 + 1);
        repeat (idle) @(posedge clock);
        #DRIVE_DELAY;
        address = cmd_address;
        words = cmd_count;
        go = 1'b1;
        push_expected(cmd_address, cmd_count);
        @(posedge clock);
        #DRIVE_DELAY;
        go = 1'b0;
        waited = 0;
        while (cmd_open) begin
            @(posedge clock);
            waited++;
            if (waited > DONE_TIMEOUT) begin
                stop_with_failure($sformatf("timeout waiting for the final beat of command %0d",
                                            index));
            end
        end
    endtask

    // memory stall and consumer credit return
    always @(posedge clock) begin
        in_reset = clock_sreset;
        #DRIVE_DELAY;
        if (in_reset) begin
            stall = 1'b0;
            out_credit = 1'b0;
            credit_gap = 0;
        end else begin
            stall = (take_bits(2) == 0);
            if (credit_gap != 0) begin
                credit_gap--;
                out_credit = 1'b0;
            end else if (beats_seen > credits_sent) begin
                out_credit = 1'b1;
                credits_sent++;
                credit_gap = take_bits(3);
                if (take_bits(5) == 0) begin
                    credit_gap += STARVE_CYCLES;   // occasional long starvation
                end
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    always @(negedge clock) begin
        if (!clock_sreset) begin
            if (go) begin
                cmd_open = 1'b1;
                next_addr = address;
                issued = 0;
                cmd_words = words;
            end
            check_value("busy", cmd_open, busy);
            if (!cmd_open) begin
                check_value("m_read", 0, m_read);
            end
            if (m_read && !m_waitrequest) begin
                check_value("m_address", next_addr, m_address);
                check_value("m_byteenable", 2'b11, m_byteenable);
                if (m_burstcount == 0 || m_burstcount > BURST_SIZE) begin
                    stop_with_failure($sformatf("burst of %0d words is out of range",
                                                m_burstcount));
                end
                next_addr = next_addr + 2 * m_burstcount;
                issued += m_burstcount;
                if (issued > cmd_words) begin
                    stop_with_failure("bursts request more words than the command holds");
                end
            end
            if (out_valid) begin
                beats_seen++;
                if (beats_seen > OUT_CREDITS + credits_seen) begin
                    stop_with_failure("a beat was sent without a credit");
                end
                if (expected_beats.size() == 0) begin
                    stop_with_failure("a beat was sent with no data expected");
                end
                check_value("out_data", expected_beats.pop_front(), out_data);
                check_value("out_last", expected_last.pop_front(), out_last);
                if (out_last) begin
                    check_value("burst word total", cmd_words, issued);
                    cmd_open = 1'b0;
                end
            end else begin
                check_value("out_last", 0, out_last);
            end
            if (out_credit) begin
                credits_seen++;
            end
        end
    end

    initial begin
        clock_sreset = 1'b1;
        address = '0;
        words = '0;
        go = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        clock_sreset = 1'b0;
        repeat (IDLE_CHECK_CYCLES) @(posedge clock);   // outputs must stay quiet
        for (n = 0; n < NUM_COMMANDS; n++) begin
            run_command(n);
        end
        @(posedge clock);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: testbench/avalon_burst_memory.sv
`timescale 1ns/1ns

module avalon_burst_memory #(
    parameter WIDTHB = 4,
    parameter READ_LATENCY = 3
) (
    input  logic                      clock,
    input  logic                      clock_sreset,
    input  logic                      stall,

    input  burst_read_pkg::address_t  m_address,
    input  logic                      m_read,
    input  logic [WIDTHB-1:0]         m_burstcount,
    output logic                      m_waitrequest,
    output burst_read_pkg::word_t     m_readdata = 16'h0000,
    output logic                      m_readdatavalid = 1'b0
);

    burst_read_pkg::address_t  pending_address [$];   // one entry per word still owed
    int unsigned               pending_due [$];       // cycle at which that word may return
    int unsigned               cycle;
    int unsigned               k;

    assign m_waitrequest = stall;

    // memory contents follow the byte address
    function automatic burst_read_pkg::word_t stored_word(input burst_read_pkg::address_t a);
        return a[15:0] ^ 16'h5a5a;
    endfunction

    always @(posedge clock) begin
        if (clock_sreset) begin
            cycle <= 0;
            m_readdatavalid <= 1'b0;
            m_readdata <= 16'h0000;
            pending_address.delete();
            pending_due.delete();
        end else begin
            cycle <= cycle + 1;
            if (m_read && !m_waitrequest) begin
                for (k = 0; k < m_burstcount; k++) begin
                    pending_address.push_back(m_address + 2 * k);
                    pending_due.push_back(cycle + READ_LATENCY);
                end
            end
            // words leave in request order at one per cycle
            if (pending_due.size() != 0 && pending_due[0] <= cycle) begin
                m_readdatavalid <= 1'b1;
                m_readdata <= stored_word(pending_address.pop_front());
                void'(pending_due.pop_front());
            end else begin
                m_readdatavalid <= 1'b0;
                m_readdata <= 16'hdead;   // idle bus value
            end
        end
    end

endmodule

// File: hw/burst_read_engine.sv
`timescale 1ns/1ns

module burst_read_engine #(
    parameter BURST_SIZE = 8,
    parameter WIDTHB = 4,
    parameter FIFO_DEPTH = 32,
    parameter OUT_CREDITS = 4
) (
    input  logic                      clock,
    input  logic                      clock_sreset,

    input  burst_read_pkg::address_t  address,
    input  burst_read_pkg::count_t    words,
    input  logic                      go,
    output logic                      busy,

    output burst_read_pkg::address_t  m_address,
    input  burst_read_pkg::word_t     m_readdata,
    output logic [1:0]                m_byteenable,
    output logic [WIDTHB-1:0]         m_burstcount,
    output logic                      m_read,
    input  logic                      m_readdatavalid,
    input  logic                      m_waitrequest,

    output logic                      out_valid,
    output burst_read_pkg::beat_t     out_data,
    output logic                      out_last,
    input  logic                      out_credit
);

    logic                   master_busy;
    logic                   packer_active;
    logic                   go_start;
    logic                   data_valid;
    logic                   data_wait;
    burst_read_pkg::word_t  data;
    burst_read_pkg::word_t  rd_data;
    logic                   rd_empty;
    logic                   rd_pop;

    // packer outlasts the master, so its state alone decides when a command may start
    assign go_start = go & ~packer_active;
    assign busy = master_busy | packer_active;

    burst_read_master #(
        .BURST_SIZE      (BURST_SIZE),
        .WIDTHB          (WIDTHB)
    ) i_burst_read_master (
        .clock           (clock),
        .clock_sreset    (clock_sreset),
        .address         (address),
        .words           (words),
        .go              (go_start),
        .data_wait       (data_wait),
        .busy            (master_busy),
        .data_valid      (data_valid),
        .data            (data),
        .m_address       (m_address),
        .m_readdata      (m_readdata),
        .m_byteenable    (m_byteenable),
        .m_burstcount    (m_burstcount),
        .m_read          (m_read),
        .m_readdatavalid (m_readdatavalid),
        .m_waitrequest   (m_waitrequest)
    );

    read_buffer #(
        .BURST_SIZE      (BURST_SIZE),
        .WIDTHB          (WIDTHB),
        .FIFO_DEPTH      (FIFO_DEPTH)
    ) i_read_buffer (
        .clock           (clock),
        .clock_sreset    (clock_sreset),
        .data            (data),
        .data_valid      (data_valid),
        .m_read          (m_read),
        .m_waitrequest   (m_waitrequest),
        .m_burstcount    (m_burstcount),
        .data_wait       (data_wait),
        .rd_pop          (rd_pop),
        .rd_data         (rd_data),
        .rd_empty        (rd_empty)
    );

    word_packer #(
        .OUT_CREDITS     (OUT_CREDITS)
    ) i_word_packer (
        .clock           (clock),
        .clock_sreset    (clock_sreset),
        .go              (go_start),
        .words           (words),
        .active          (packer_active),
        .rd_data         (rd_data),
        .rd_empty        (rd_empty),
        .rd_pop          (rd_pop),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_last        (out_last),
        .out_credit      (out_credit)
    );

endmodule

// File: hw/word_packer.sv
`timescale 1ns/1ns

module word_packer #(
    parameter OUT_CREDITS = 4
) (
    input  logic                    clock,
    input  logic                    clock_sreset,

    input  logic                    go,
    input  burst_read_pkg::count_t  words,
    output logic                    active,

    input  burst_read_pkg::word_t   rd_data,
    input  logic                    rd_empty,
    output logic                    rd_pop,

    output logic                    out_valid,
    output burst_read_pkg::beat_t   out_data,
    output logic                    out_last,
    input  logic                    out_credit
);

    localparam int CRW = $clog2(OUT_CREDITS + 1);

    burst_read_pkg::count_t  remain;     // words still to pop for this command
    burst_read_pkg::word_t   low_word;   // earlier half of the beat being built
    logic                    have_low;
    logic [CRW-1:0]          credits;
    logic                    last_word;
    logic                    beat_fire;

    assign last_word = (remain == burst_read_pkg::count_t'(1));

    // no pops without a credit in hand
    assign rd_pop = active & ~rd_empty & (remain != '0) & (credits != '0);

    // this pop completes a beat, a pair or the odd final word
    assign beat_fire = rd_pop & (have_low | last_word);

    always_ff @(posedge clock) begin
        if (rd_pop && !beat_fire) begin
            low_word <= rd_data;
        end
        if (beat_fire) begin
            if (have_low) begin
                out_data <= {rd_data, low_word};
            end else begin
                out_data <= {16'h0000, rd_data};   // odd tail
            end
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            active <= 1'b0;
            remain <= '0;
            have_low <= 1'b0;
            credits <= CRW'(OUT_CREDITS);
            out_valid <= 1'b0;
            out_last <= 1'b0;
        end else begin
            out_valid <= beat_fire;
            out_last <= beat_fire & last_word;

            // the credit is taken when the beat is committed, a cycle before out_valid
            credits <= credits + CRW'(out_credit) - CRW'(beat_fire);

            if (!active) begin
                have_low <= 1'b0;
                if (go) begin
                    active <= 1'b1;
                    remain <= words;
                end
            end else begin
                if (rd_pop) begin
                    remain <= remain - 1'b1;
                    have_low <= ~beat_fire;
                end
                if (out_valid && out_last) begin
                    active <= 1'b0;   // stays up through the final beat
                end
            end
        end
    end

endmodule

// File: hw/read_buffer.sv
`timescale 1ns/1ns

module read_buffer #(
    parameter BURST_SIZE = 8,
    parameter WIDTHB = 4,
    parameter FIFO_DEPTH = 32
) (
    input  logic                   clock,
    input  logic                   clock_sreset,

    input  burst_read_pkg::word_t  data,
    input  logic                   data_valid,
    input  logic                   m_read,
    input  logic                   m_waitrequest,
    input  logic [WIDTHB-1:0]      m_burstcount,
    output logic                   data_wait,

    input  logic                   rd_pop,
    output burst_read_pkg::word_t  rd_data,
    output logic                   rd_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1) + 1;
    localparam logic [CW-1:0] DEPTH_C = CW'(FIFO_DEPTH);
    localparam logic [CW-1:0] MARGIN = CW'(2 * BURST_SIZE);   // covers the reserved lag

    burst_read_pkg::word_t  mem [FIFO_DEPTH];
    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic [CW-1:0]          fill;
    logic [CW-1:0]          reserved;   // words promised to accepted bursts, not yet popped
    logic [CW-1:0]          granted;
    logic                   accepted;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign accepted = m_read & ~m_waitrequest;
    assign granted = accepted ? CW'(m_burstcount) : '0;

    assign rd_empty = (fill == '0);
    assign rd_data = mem[rd_ptr];   // show-ahead read
    assign data_wait = (reserved + MARGIN) > DEPTH_C;

    always_ff @(posedge clock) begin
        if (data_valid) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            reserved <= '0;
        end else begin
            if (data_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill <= fill + CW'(data_valid) - CW'(rd_pop);
            reserved <= reserved + granted - CW'(rd_pop);
        end
    end

endmodule

// File: hw/burst_read_master.sv
`timescale 1ns/1ns

module burst_read_master #(
    parameter BURST_SIZE = 8,
    parameter WIDTHB = 4
) (
    input  logic                      clock,
    input  logic                      clock_sreset,

    input  burst_read_pkg::address_t  address,
    input  burst_read_pkg::count_t    words,
    input  logic                      go,
    input  logic                      data_wait,
    output logic                      busy,
    output logic                      data_valid,
    output burst_read_pkg::word_t     data,

    output burst_read_pkg::address_t  m_address,
    input  burst_read_pkg::word_t     m_readdata,
    output logic [1:0]                m_byteenable,
    output logic [WIDTHB-1:0]         m_burstcount,
    output logic                      m_read,
    input  logic                      m_readdatavalid,
    input  logic                      m_waitrequest
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } state_t;

    state_t                  state;
    burst_read_pkg::count_t  issue_left;    // words not yet requested
    burst_read_pkg::count_t  return_left;   // words not yet returned by the bus
    burst_read_pkg::count_t  next_burst;
    logic                    accepted;
    logic                    full_burst;
    logic                    load_burst;

    assign accepted = m_read & ~m_waitrequest;
    assign full_burst = (issue_left >= burst_read_pkg::count_t'(BURST_SIZE));
    assign next_burst = full_burst ? burst_read_pkg::count_t'(BURST_SIZE) : issue_left;

    // a new request may go out once the bus slot is free and the buffer has room
    assign load_burst = (state == ISSUE) & (~m_read | accepted) &
                        (issue_left != '0) & ~data_wait;

    assign busy = (state != IDLE) | go;   // bus phase only
    assign m_byteenable = 2'b11;          // whole words only

    // returned words leave one cycle after the bus presents them
    always_ff @(posedge clock) begin
        data <= m_readdata;
        if (clock_sreset) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= m_readdatavalid;
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE) begin
            m_address <= address;
        end else if (accepted) begin
            m_address <= m_address +
                (burst_read_pkg::address_t'(m_burstcount) << burst_read_pkg::WORD_SHIFT);
        end
        if (load_burst) begin
            m_burstcount <= next_burst[WIDTHB-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= IDLE;
            m_read <= 1'b0;
            issue_left <= '0;
            return_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    m_read <= 1'b0;
                    if (go) begin
                        issue_left <= words;
                        return_left <= words;
                        state <= ISSUE;
                    end
                end
                ISSUE: begin
                    return_left <= return_left -
                        burst_read_pkg::count_t'(m_readdatavalid);
                    if (load_burst) begin
                        m_read <= 1'b1;
                        issue_left <= issue_left - next_burst;
                    end else if (accepted) begin
                        m_read <= 1'b0;   // held back by data_wait or all issued
                        if (issue_left == '0) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    return_left <= return_left -
                        burst_read_pkg::count_t'(m_readdatavalid);
                    if (return_left == '0) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    m_read <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/burst_read_pkg.sv
package burst_read_pkg;

    // byte address on the memory bus
    typedef logic [31:0] address_t;

    // one bus data word
    typedef logic [15:0] word_t;

    // one output beat, earlier word in the lower half
    typedef logic [31:0] beat_t;

    // count of words in a command or a burst
    typedef logic [15:0] count_t;

    // byte address step per word is 1 << WORD_SHIFT
    localparam int WORD_SHIFT = 1;

endpackage
